/* sifh_params.svh */
/* Widths and counts for the histogram peak finder.
   NP must be at least 2*NB, so a fine window never leaves the stamp range.
   CNT_W must hold DATA_NUM*ACQ_NUM, the largest count a bin can reach */

`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// ****************************
// Data path widths
// ****************************
`define NP 10           // Timestamp width
`define NB 4            // Bin address width, 16 bins per histogram
`define CNT_W 6         // Bin count width

// ****************************
// Acquisition geometry
// ****************************
`define PIXELS 2        // Pixels sharing one histogram memory
`define PIX_W 1         // Pixel index width
`define DATA_NUM 4      // Samples per pixel per acquisition
`define ACQ_NUM 4       // Acquisitions per pass

`endif

/* sifhPkg.sv */
/* Shared vector types and the pass encoding.
   Widths come from the params header */

`include "sifh_params.svh"

package sifhPkg;

    // Timestamp as delivered by the detector
    typedef logic [`NP-1:0] stampT;

    // Bin index inside one pixel histogram
    typedef logic [`NB-1:0] binT;

    typedef logic [`PIX_W-1:0] pixT;

    // Occupancy of one bin
    typedef logic [`CNT_W-1:0] cntT;

    // Memory address, pixel in the upper bits
    typedef logic [`PIX_W+`NB-1:0] ramAddrT;

    // Coarse pass bins on top bits, fine pass bins inside the window
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passT;

endpackage

/* windowFilter.sv */
/* Per-pixel window and bin address generation.
   binAddr and keep follow data without a register.
   A window is loaded on passDone in the coarse pass, a result is emitted in the fine pass */

`include "sifh_params.svh"

module windowFilter (
    input  logic            clk,
    input  logic            combin_res,
    input  sifhPkg::stampT  data,
    input  sifhPkg::pixT    pixel,
    input  sifhPkg::passT   pass,
    output sifhPkg::binT    binAddr,
    output logic            keep,
    input  logic            passDone,
    input  sifhPkg::pixT    peakPixel,
    input  sifhPkg::binT    peakBin,
    output logic            resultValid,
    output sifhPkg::pixT    resultPixel,
    output sifhPkg::stampT  resultStamp
);

    localparam int SHIFT = `NP - `NB;     // Stamps per coarse bin, as a power of two
    localparam sifhPkg::stampT BINS = sifhPkg::stampT'(1 << `NB);
    localparam sifhPkg::stampT HALF_COARSE = sifhPkg::stampT'(1 << (SHIFT - 1));
    localparam sifhPkg::stampT HALF_WIN = sifhPkg::stampT'(1 << (`NB - 1));

    sifhPkg::stampT winBase [`PIXELS];
    sifhPkg::stampT curBase;
    sifhPkg::stampT offset;
    sifhPkg::stampT newBase;

    // ****************************
    // Sample filtering
    // ****************************
    always_comb begin
        curBase = winBase[pixel];
        offset  = data - curBase;
        if (pass == sifhPkg::COARSE) begin
            binAddr = data[`NP-1 -: `NB];   // Top bits select the coarse bin
            keep    = 1'b1;
        end else begin
            binAddr = offset[`NB-1:0];
            keep    = (data >= curBase) && (offset < BINS);
        end
    end

    // Window centred on the middle of the coarse peak bin
    assign newBase = (sifhPkg::stampT'(peakBin) << SHIFT) + HALF_COARSE - HALF_WIN;

    // ****************************
    // Window load and result
    // ****************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < `PIXELS; i++) begin
                winBase[i] <= '0;
            end
            resultValid <= 1'b0;
        end else begin
            resultValid <= passDone && (pass == sifhPkg::FINE);
            if (passDone && (pass == sifhPkg::COARSE)) begin
                winBase[peakPixel] <= newBase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (passDone && (pass == sifhPkg::FINE)) begin
            resultPixel <= peakPixel;
            resultStamp <= winBase[peakPixel] + sifhPkg::stampT'(peakBin);  // Base plus fine peak
        end
    end

endmodule

/* histRam.sv */
/* Shared histogram memory, PIXELS*2^NB counts with one valid bit each.
   ramData is valid one cycle after an access; an increment returns the new count.
   clearAll drops the valid bits only, so a cleared bin reads as 0 */

`include "sifh_params.svh"

module histRam (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              ramEn,
    input  logic              ramInc,
    input  sifhPkg::ramAddrT  ramAddr,
    input  logic              clearAll,
    output sifhPkg::cntT      ramData
);

    localparam int DEPTH = `PIXELS * (1 << `NB);

    sifhPkg::cntT mem [DEPTH];
    logic [DEPTH-1:0] valid;

    sifhPkg::cntT memQ;                 // Raw word read in the access cycle
    logic validQ;
    logic incQ;
    sifhPkg::ramAddrT addrQ;

    // Last written word, the array read of the same edge misses it
    logic byValid;
    sifhPkg::ramAddrT byAddr;
    sifhPkg::cntT byData;

    sifhPkg::cntT oldCnt;
    sifhPkg::cntT incData;

    always_comb begin
        if (byValid && (byAddr == addrQ)) begin
            oldCnt = byData;
        end else begin
            oldCnt = validQ ? memQ : '0;
        end
        incData = oldCnt + 1'b1;
        ramData = incQ ? incData : oldCnt;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid   <= '0;
            validQ  <= 1'b0;
            incQ    <= 1'b0;
            byValid <= 1'b0;
        end else begin
            incQ    <= ramEn && ramInc;
            validQ  <= valid[ramAddr] && !clearAll;
            byValid <= incQ && !clearAll;
            if (incQ) begin
                valid[addrQ] <= 1'b1;
            end
            if (clearAll) begin
                valid <= '0;            // Lazy clear, counts stay in the array
            end
        end
    end

    // Array and payload
    always_ff @(posedge clk) begin
        if (ramEn) begin
            memQ  <= mem[ramAddr];
            addrQ <= ramAddr;
        end
        if (incQ) begin
            mem[addrQ] <= incData;      // Write back of the read-modify-write
            byAddr     <= addrQ;
            byData     <= incData;
        end
    end

endmodule

/* histArbiter.sv */
/* Fixed priority access to histRam, builder increments first.
   One host read can wait in the pending slot; a second one must not arrive meanwhile */

`include "sifh_params.svh"

module histArbiter (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              incEn,
    input  sifhPkg::ramAddrT  incAddr,
    input  logic              rdReq,
    input  sifhPkg::ramAddrT  rdAddr,
    output logic              ramEn,
    output logic              ramInc,
    output sifhPkg::ramAddrT  ramAddr,
    input  sifhPkg::cntT      ramData,
    output logic              rdValid,
    output sifhPkg::cntT      rdData
);

    logic pendValid;
    sifhPkg::ramAddrT pendAddr;
    logic hostGo;                       // Host owns the memory this cycle
    logic hostQ;                        // Host owned the previous access

    assign hostGo  = !incEn && (pendValid || rdReq);
    assign ramEn   = incEn || hostGo;
    assign ramInc  = incEn;

    always_comb begin
        if (incEn) begin
            ramAddr = incAddr;
        end else if (pendValid) begin
            ramAddr = pendAddr;         // Older request goes first
        end else begin
            ramAddr = rdAddr;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pendValid <= 1'b0;
            hostQ     <= 1'b0;
        end else begin
            hostQ <= hostGo;
            if (incEn && rdReq) begin
                pendValid <= 1'b1;      // Blocked by an increment, park it
            end else if (hostGo) begin
                pendValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (incEn && rdReq) begin
            pendAddr <= rdAddr;
        end
    end

    // Increment results stay inside the builder path
    assign rdValid = hostQ;
    assign rdData  = hostQ ? ramData : '0;

endmodule

/* histBuilder.sv */
/* Sample counting, pass sequencing and per-pixel peak tracking.
   Counters nest as sample, then pixel, then acquisition.
   ready is low for PIXELS+2 cycles after the last sample of a pass */

`include "sifh_params.svh"

module histBuilder (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    output logic              ready,
    output sifhPkg::pixT      pixel,
    output sifhPkg::passT     pass,
    input  logic              keep,
    input  sifhPkg::binT      binAddr,
    output logic              incEn,
    output sifhPkg::ramAddrT  incAddr,
    input  sifhPkg::cntT      ramData,
    output logic              clearAll,
    output logic              passDone,
    output sifhPkg::pixT      peakPixel,
    output sifhPkg::binT      peakBin
);

    localparam int SMP_W = $clog2(`DATA_NUM + 1);
    localparam int ACQ_W = $clog2(`ACQ_NUM + 1);
    localparam int SW_W  = $clog2(`PIXELS + 2);

    localparam logic [SMP_W-1:0] SMP_LAST = SMP_W'(`DATA_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(`ACQ_NUM - 1);
    localparam sifhPkg::pixT PIX_LAST = sifhPkg::pixT'(`PIXELS - 1);
    localparam logic [SW_W-1:0] SW_LAST = SW_W'(`PIXELS + 1);   // clearAll step

    logic [SMP_W-1:0] smpCnt;
    sifhPkg::pixT pixCnt;
    logic [ACQ_W-1:0] acqCnt;

    logic accept;
    logic lastSample;
    logic switching;
    logic [SW_W-1:0] swCnt;

    sifhPkg::cntT maxCnt [`PIXELS];
    sifhPkg::binT maxBin [`PIXELS];
    logic incQ;
    sifhPkg::pixT pixQ;
    sifhPkg::binT binQ;

    assign ready      = !switching;
    assign accept     = wrEn && ready;
    assign lastSample = accept && (smpCnt == SMP_LAST) && (pixCnt == PIX_LAST)
                        && (acqCnt == ACQ_LAST);

    assign pixel   = pixCnt;
    assign incEn   = accept && keep;     // Dropped samples still advance the counters
    assign incAddr = {pixCnt, binAddr};

    // ****************************
    // Sample counters
    // ****************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smpCnt <= '0;
            pixCnt <= '0;
            acqCnt <= '0;
        end else if (accept) begin
            if (smpCnt == SMP_LAST) begin
                smpCnt <= '0;
                if (pixCnt == PIX_LAST) begin
                    pixCnt <= '0;
                    acqCnt <= (acqCnt == ACQ_LAST) ? '0 : acqCnt + 1'b1;
                end else begin
                    pixCnt <= pixCnt + 1'b1;
                end
            end else begin
                smpCnt <= smpCnt + 1'b1;
            end
        end
    end

    // ****************************
    // Pass switch sequence
    // ****************************
    // swCnt 0 waits for the last count, 1..PIXELS step out peaks, then clear
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pass      <= sifhPkg::COARSE;
            switching <= 1'b0;
            swCnt     <= '0;
        end else if (!switching) begin
            if (lastSample) begin
                switching <= 1'b1;
                swCnt     <= '0;
            end
        end else if (swCnt == SW_LAST) begin
            switching <= 1'b0;
            pass      <= (pass == sifhPkg::COARSE) ? sifhPkg::FINE : sifhPkg::COARSE;
        end else begin
            swCnt <= swCnt + 1'b1;
        end
    end

    assign passDone  = switching && (swCnt != '0) && (swCnt != SW_LAST);
    assign clearAll  = switching && (swCnt == SW_LAST);
    assign peakPixel = sifhPkg::pixT'(swCnt - 1'b1);
    assign peakBin   = maxBin[peakPixel];

    // ****************************
    // Peak tracking
    // ****************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            incQ <= 1'b0;
            for (int i = 0; i < `PIXELS; i++) begin
                maxCnt[i] <= '0;
                maxBin[i] <= '0;
            end
        end else begin
            incQ <= incEn;
            if (incQ && (ramData > maxCnt[pixQ])) begin    // Strictly greater, ties keep old bin
                maxCnt[pixQ] <= ramData;
                maxBin[pixQ] <= binQ;
            end
            if (passDone) begin
                maxCnt[peakPixel] <= '0;
                maxBin[peakPixel] <= '0;
            end
        end
    end

    // Pixel and bin of the increment in flight
    always_ff @(posedge clk) begin
        pixQ <= pixCnt;
        binQ <= binAddr;
    end

endmodule

/* sifhTop.sv */
/* Two-pass histogram peak finder for one pixel group.
   Samples are taken only while ready is high; outputs are single-cycle pulses */

`include "sifh_params.svh"

module sifhTop (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    input  sifhPkg::stampT    data,
    input  logic              rdReq,
    input  sifhPkg::ramAddrT  rdAddr,
    output logic              ready,
    output logic              rdValid,
    output sifhPkg::cntT      rdData,
    output logic              resultValid,
    output sifhPkg::pixT      resultPixel,
    output sifhPkg::stampT    resultStamp
);

    sifhPkg::pixT     pixel;
    sifhPkg::passT    pass;
    sifhPkg::binT     binAddr;
    logic             keep;
    logic             incEn;
    sifhPkg::ramAddrT incAddr;
    logic             ramEn;
    logic             ramInc;
    sifhPkg::ramAddrT ramAddr;
    sifhPkg::cntT     ramData;
    logic             clearAll;
    logic             passDone;
    sifhPkg::pixT     peakPixel;
    sifhPkg::binT     peakBin;

    windowFilter uFilter (
        .clk(clk), .combin_res(combin_res), .data(data), .pixel(pixel), .pass(pass),
        .binAddr(binAddr), .keep(keep), .passDone(passDone), .peakPixel(peakPixel),
        .peakBin(peakBin), .resultValid(resultValid), .resultPixel(resultPixel),
        .resultStamp(resultStamp)
    );

    histBuilder uBuilder (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .ready(ready), .pixel(pixel),
        .pass(pass), .keep(keep), .binAddr(binAddr), .incEn(incEn), .incAddr(incAddr),
        .ramData(ramData), .clearAll(clearAll), .passDone(passDone),
        .peakPixel(peakPixel), .peakBin(peakBin)
    );

    histArbiter uArbiter (
        .clk(clk), .combin_res(combin_res), .incEn(incEn), .incAddr(incAddr),
        .rdReq(rdReq), .rdAddr(rdAddr), .ramEn(ramEn), .ramInc(ramInc),
        .ramAddr(ramAddr), .ramData(ramData), .rdValid(rdValid), .rdData(rdData)
    );

    histRam uRam (
        .clk(clk), .combin_res(combin_res), .ramEn(ramEn), .ramInc(ramInc),
        .ramAddr(ramAddr), .clearAll(clearAll), .ramData(ramData)
    );

endmodule

/* tbClock.sv */
/* Free running clock, reset held low for RST_CYCLES periods.
   Reset is released on a falling edge */

module tbClock #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic combin_res
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        combin_res = 1'b0;
        #(PERIOD * RST_CYCLES) combin_res = 1'b1;
    end

endmodule

/* sifhTop_assert.sv */
/* Protocol checks, bound into sifhTop.
   The pending slot is mirrored here from incEn and rdReq.
   failCount holds the number of failed assertions */

`include "sifh_params.svh"

module sifhTop_assert (
    input logic          clk,
    input logic          combin_res,
    input logic          wrEn,
    input logic          ready,
    input logic          rdReq,
    input logic          incEn,
    input logic          rdValid,
    input logic          resultValid,
    input sifhPkg::passT pass
);

    logic pendValid;                    // Host read parked behind an increment
    logic [3:0] outstanding;
    logic [3:0] resCnt;                 // Results seen in the current fine pass
    int failCount = 0;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pendValid   <= 1'b0;
            outstanding <= '0;
            resCnt      <= '0;
        end else begin
            if (incEn && rdReq) begin
                pendValid <= 1'b1;
            end else if (!incEn) begin
                pendValid <= 1'b0;
            end
            outstanding <= outstanding + 4'(rdReq) - 4'(rdValid);
            resCnt      <= (pass == sifhPkg::COARSE) ? 4'd0 : resCnt + 4'(resultValid);
        end
    end

    assert property (@(posedge clk) disable iff (!combin_res) wrEn |-> ready)
        else begin
            $error("wrEn while ready is low");
            failCount++;
        end
    assert property (@(posedge clk) disable iff (!combin_res) rdReq |-> !pendValid)
        else begin
            $error("rdReq while a host read is pending");
            failCount++;
        end
    assert property (@(posedge clk) disable iff (!combin_res) rdValid |-> outstanding != 0)
        else begin
            $error("rdValid without an earlier rdReq");
            failCount++;
        end
    assert property (@(posedge clk) disable iff (!combin_res)
        ($past(pass) == sifhPkg::FINE && pass == sifhPkg::COARSE) |-> resCnt == 4'(`PIXELS))
        else begin
            $error("wrong number of resultValid pulses in the fine pass");
            failCount++;
        end

endmodule

/* sifhTb.sv */
/* Runs the stimulus table frame after frame with no reset in between.
   Host reads and results are compared with a bin count and peak model */

`include "sifh_params.svh"

module sifhTb;

    localparam int BINS  = 1 << `NB;
    localparam int DEPTH = `PIXELS * BINS;
    localparam int NPASS = `PIXELS * `DATA_NUM * `ACQ_NUM;    // Samples per pass
    localparam int ROWS  = 4;

    typedef struct packed {
        logic           mode;           // 0 cluster with a tie, 1 LCG spread
        sifhPkg::stampT cen0;
        sifhPkg::stampT cen1;
        sifhPkg::binT   coarse0;        // Expected coarse peaks
        sifhPkg::binT   coarse1;
    } rowT;

    logic clk;
    logic combin_res;
    logic wrEn;
    logic rdReq;
    logic ready;
    logic rdValid;
    logic resultValid;
    sifhPkg::stampT data;
    sifhPkg::ramAddrT rdAddr;
    sifhPkg::cntT rdData;
    sifhPkg::pixT resultPixel;
    sifhPkg::stampT resultStamp;

    // Centres sit 30 stamps into their coarse bin
    rowT stimTable [ROWS] = '{
        '{1'b0, 10'd94,  10'd542, 4'd1,  4'd8},
        '{1'b1, 10'd350, 10'd734, 4'd5,  4'd11},
        '{1'b0, 10'd990, 10'd30,  4'd15, 4'd0},
        '{1'b1, 10'd222, 10'd222, 4'd3,  4'd3}
    };
    // Offsets 5 and 0 tie at five counts and 5 gets there first
    int clusterOfs [`DATA_NUM*`ACQ_NUM] = '{5, 0, 0, 5, 5, 0, 0, 5, 7, 9, -2, 300, 5, 0, -20, 600};

    int mdlCnt [DEPTH];
    int mdlMax [`PIXELS];
    int mdlBin [`PIXELS];
    int winBase [`PIXELS];
    int resCount = 0;
    logic [31:0] lcgState = 32'd34239;
    sifhPkg::pixT gotPix [ROWS*`PIXELS];
    sifhPkg::stampT gotStamp [ROWS*`PIXELS];

    tbClock #(.PERIOD(4), .RST_CYCLES(16)) uClock (.clk(clk), .combin_res(combin_res));

    sifhTop dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .data(data), .rdReq(rdReq),
        .rdAddr(rdAddr), .ready(ready), .rdValid(rdValid), .rdData(rdData),
        .resultValid(resultValid), .resultPixel(resultPixel), .resultStamp(resultStamp)
    );

    bind sifhTop sifhTop_assert uAssert (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .ready(ready), .rdReq(rdReq),
        .incEn(incEn), .rdValid(rdValid), .resultValid(resultValid), .pass(pass)
    );

    // ******************************
    // Helpers
    // ******************************
    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    function automatic sifhPkg::stampT makeStamp(logic mode, sifhPkg::stampT cen, int k);
        int ofs;
        if (!mode) begin
            ofs = clusterOfs[k];
        end else if (k % 4 == 3) begin
            ofs = 256 + nextRand() % 64;    // Far outside any fine window
        end else begin
            ofs = nextRand() % 13 - 6;
        end
        return sifhPkg::stampT'(int'(cen) + ofs);
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        while (!ready) begin
            if (n == 40) begin
                abortRun("Timed out waiting for ready");
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    task automatic waitRead(input int exp);
        int n;
        n = 0;
        while (!rdValid) begin
            if (n == 20) begin
                abortRun("Timed out waiting for rdValid");
            end else begin
                n++;
                @(negedge clk);
            end
        end
        compareValue("rdData", rdData, exp);
    endtask

    task automatic hostRead(input int addr, input int exp);
        rdReq  = 1'b1;
        rdAddr = sifhPkg::ramAddrT'(addr);
        @(negedge clk);
        rdReq = 1'b0;
        waitRead(exp);
    endtask

    // Model of one accepted sample where strict greater keeps the earlier bin
    task automatic modelSample(input bit fine, input int p, input sifhPkg::stampT s,
                               output bit kept, output int bin);
        if (!fine) begin
            bin  = int'(s) >> (`NP - `NB);
            kept = 1'b1;
        end else begin
            bin  = int'(s) - winBase[p];
            kept = (bin >= 0) && (bin < BINS);
        end
        if (kept) begin
            mdlCnt[p*BINS + bin]++;
            if (mdlCnt[p*BINS + bin] > mdlMax[p]) begin
                mdlMax[p] = mdlCnt[p*BINS + bin];
                mdlBin[p] = bin;
            end
        end
    endtask

    task automatic sendSample(input bit fine, input int p, input sifhPkg::stampT s,
                              input bit withRead);
        bit kept;
        int bin;
        waitReady();
        modelSample(fine, p, s, kept, bin);
        if (!kept) begin
            bin = nextRand() % BINS;        // Any bin must stay put for a dropped sample
        end
        wrEn   = 1'b1;
        data   = s;
        rdReq  = withRead;
        rdAddr = sifhPkg::ramAddrT'(p*BINS + bin);
        @(negedge clk);
        wrEn  = 1'b0;
        rdReq = 1'b0;
        if (withRead) begin
            waitRead(mdlCnt[p*BINS + bin]);
        end
    endtask

    task automatic runPass(input int row, input bit fine);
        int p;
        int k;
        int a;
        sifhPkg::stampT cen;
        for (a = 0; a < DEPTH; a++) begin
            mdlCnt[a] = 0;
        end
        for (p = 0; p < `PIXELS; p++) begin
            mdlMax[p] = 0;
            mdlBin[p] = 0;
        end
        waitReady();
        for (a = 0; a < DEPTH; a++) begin
            hostRead(a, 0);                 // Nothing written since clearAll or reset
        end
        for (int i = 0; i < NPASS; i++) begin
            p   = (i / `DATA_NUM) % `PIXELS;
            k   = (i / (`DATA_NUM * `PIXELS)) * `DATA_NUM + i % `DATA_NUM;
            cen = (p == 0) ? stimTable[row].cen0 : stimTable[row].cen1;
            sendSample(fine, p, makeStamp(stimTable[row].mode, cen, k), nextRand() % 4 == 0);
            if (nextRand() % 6 == 0) begin
                a = nextRand() % DEPTH;
                hostRead(a, mdlCnt[a]);
            end
            repeat (nextRand() % 3) @(negedge clk);
        end
    endtask

    // Results can land while the main thread waits on a read
    always @(negedge clk) begin
        if (resultValid && resCount < ROWS * `PIXELS) begin
            gotPix[resCount]   = resultPixel;
            gotStamp[resCount] = resultStamp;
            resCount++;
        end
    end

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        int n;
        wrEn   = 1'b0;
        data   = '0;
        rdReq  = 1'b0;
        rdAddr = '0;
        n = 0;
        while (combin_res !== 1'b1) begin
            if (n == 40) begin
                abortRun("Reset was never released");
            end else begin
                n++;
                @(negedge clk);
            end
        end
        compareValue("ready", ready, 1);
        for (int row = 0; row < ROWS; row++) begin
            runPass(row, 1'b0);
            compareValue("coarsePeak0", mdlBin[0], stimTable[row].coarse0);
            compareValue("coarsePeak1", mdlBin[1], stimTable[row].coarse1);
            for (int p = 0; p < `PIXELS; p++) begin
                winBase[p] = (mdlBin[p] << (`NP - `NB)) + (1 << (`NP - `NB - 1)) - BINS / 2;
            end
            runPass(row, 1'b1);
            n = 0;
            while (resCount < (row + 1) * `PIXELS) begin
                if (n == 40) begin
                    abortRun("Timed out waiting for resultValid");
                end else begin
                    n++;
                    @(negedge clk);
                end
            end
            for (int p = 0; p < `PIXELS; p++) begin
                compareValue("resultPixel", gotPix[row*`PIXELS + p], p);
                compareValue("resultStamp", gotStamp[row*`PIXELS + p], winBase[p] + mdlBin[p]);
            end
        end
        waitReady();
        if (dut.uAssert.failCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abortRun("A protocol assertion failed during the run");
        end
    end

endmodule

/* sifhTop.f */
+incdir+.
sifhPkg.sv
windowFilter.sv
histRam.sv
histArbiter.sv
histBuilder.sv
sifhTop.sv
tbClock.sv
sifhTop_assert.sv
sifhTb.sv

/* Makefile */
# Verilator build and run for the histogram peak finder testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module sifhTb -f sifhTop.f

run: compile
	./obj_dir/VsifhTb | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
